// File: fg_settings.svh
`ifndef FG_SETTINGS_SVH
`define FG_SETTINGS_SVH

// width of one pattern word
// matches the parallel input of the serializer fed downstream
`define FG_DATA_WIDTH 8

// pattern ram address width
// 11 bits gives 2048 words per channel
`define FG_ADDR_WIDTH 11

// number of playback channels
// each channel owns one ram and one loop sequencer
`define FG_CHANNELS 4

`endif

// File: fg_pkg.sv
`include "fg_settings.svh"

package fg_pkg;

	// bits needed to name a channel
	// kept at one bit or more so a single channel build still has a field
	localparam int chan_bits = (`FG_CHANNELS > 1) ? $clog2(`FG_CHANNELS) : 1;

	// one pattern word as replayed to the serializer
	typedef logic [`FG_DATA_WIDTH-1:0] word_t;

	// address into one channel's pattern ram
	typedef logic [`FG_ADDR_WIDTH-1:0] addr_t;

	// channel index
	typedef logic [chan_bits-1:0] chan_t;

	// one host pattern write
	// channel picks the ram, address and data go to it
	typedef struct packed {
		chan_t channel;
		addr_t address;
		word_t data;
	} write_req_t;

	// playback loop for one channel
	// replays start_address up to end_address minus one
	// equal values mean the whole ram
	typedef struct packed {
		addr_t start_address;
		addr_t end_address;
	} loop_bounds_t;

	// all channel words side by side, indexed by channel
	typedef word_t [`FG_CHANNELS-1:0] word_vec_t;

endpackage

// File: fg_host_port.sv
`timescale 1ns/1ns

`include "fg_settings.svh"

module fg_host_port (
	input logic clock,
	input logic reset,
	// pattern write, one word per strobe
	input logic write_strobe,
	input fg_pkg::write_req_t write_request,
	// loop bound update for the named channel
	input logic bounds_strobe,
	input fg_pkg::chan_t bounds_channel,
	input fg_pkg::loop_bounds_t bounds_in,
	// write side of every pattern ram
	output logic [`FG_CHANNELS-1:0] ram_write,
	output fg_pkg::addr_t ram_address,
	output fg_pkg::word_t ram_data,
	// bounds currently held for each channel
	output fg_pkg::loop_bounds_t bounds [`FG_CHANNELS]
);

	import fg_pkg::*;

	// host write captured on the strobe edge
	write_req_t write_q;
	// set for exactly one cycle after each write strobe
	logic write_valid;

	// strobe delayed to line up with the registered request
	always_ff @(posedge clock) begin
		if (reset) begin
			write_valid <= 1'b0;
		end else begin
			write_valid <= write_strobe;
		end
	end

	// address, data and channel of the pending write
	always_ff @(posedge clock) begin
		if (write_strobe) begin
			write_q <= write_request;
		end
	end

	// every ram sees the same address and data
	assign ram_address = write_q.address;
	assign ram_data = write_q.data;

	// one hot decode of the target channel
	// only the named ram writes, and only in the valid cycle
	always_comb begin
		for (int ch = 0; ch < `FG_CHANNELS; ch++) begin
			ram_write[ch] = write_valid && (write_q.channel == chan_t'(ch));
		end
	end

	// per channel bounds registers
	// all zero after reset, which plays the full ram
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int ch = 0; ch < `FG_CHANNELS; ch++) begin
				bounds[ch] <= '0;
			end
		end else if (bounds_strobe) begin
			// sequencer picks these up at its next wrap
			bounds[bounds_channel] <= bounds_in;
		end
	end

endmodule

// File: pattern_ram.sv
`timescale 1ns/1ns

`include "fg_settings.svh"

module pattern_ram #(
	parameter int depth_bits = `FG_ADDR_WIDTH
) (
	input logic clock,
	// write port, driven from the host side
	input logic write_enable,
	input logic [depth_bits-1:0] write_address,
	input fg_pkg::word_t write_data,
	// read port, driven by the loop sequencer
	input logic [depth_bits-1:0] read_address,
	output fg_pkg::word_t read_data
);

	import fg_pkg::*;

	// one word per address
	// maps onto a block ram with a registered read
	word_t memory [2**depth_bits];

	// write side
	always_ff @(posedge clock) begin
		if (write_enable) begin
			memory[write_address] <= write_data;
		end
	end

	// registered read returns data one cycle after the address
	// same address on both ports returns the old word
	always_ff @(posedge clock) begin
		read_data <= memory[read_address];
	end

endmodule

// File: loop_sequencer.sv
`timescale 1ns/1ns

module loop_sequencer (
	input logic clock,
	input logic reset,
	// bounds held by the host port for this channel
	input fg_pkg::loop_bounds_t bounds,
	// address into this channel's pattern ram
	output fg_pkg::addr_t read_address
);

	import fg_pkg::*;

	// address at which the current loop ends
	// loaded from the bounds only when the loop wraps
	addr_t last_address;

	// values for the next cycle
	addr_t next_read_address;
	addr_t next_last_address;

	// high in the cycle that reads the final word of the loop
	logic at_last;

	assign at_last = (read_address == last_address);

	// wrap or count
	// new bounds are taken only here, so a running loop always finishes
	always_comb begin
		next_read_address = read_address + 1'b1;
		next_last_address = last_address;
		if (at_last) begin
			next_read_address = bounds.start_address;
			// end is exclusive
			// address width makes this wrap modulo the ram depth
			next_last_address = bounds.end_address - 1'b1;
		end
	end

	// start at address 0 and run through the whole ram first
	// last all ones lets the first pass reach the top address
	always_ff @(posedge clock) begin
		if (reset) begin
			read_address <= '0;
			last_address <= '1;
		end else begin
			read_address <= next_read_address;
			last_address <= next_last_address;
		end
	end

endmodule

// File: fg_output_stage.sv
`timescale 1ns/1ns

`include "fg_settings.svh"

module fg_output_stage (
	input logic clock,
	input logic reset,
	// one enable level per channel
	input logic [`FG_CHANNELS-1:0] output_enable,
	// words straight from the pattern rams
	input fg_pkg::word_vec_t read_data,
	// aligned, masked words toward the serializers
	output fg_pkg::word_vec_t data_out
);

	// all channels share one clock edge
	// so words leave the stage lined up with each other
	// enable is sampled here so masking lags it by one cycle
	always_ff @(posedge clock) begin
		for (int ch = 0; ch < `FG_CHANNELS; ch++) begin
			if (reset || !output_enable[ch]) begin
				// disabled channel drives zero
				data_out[ch] <= '0;
			end else begin
				data_out[ch] <= read_data[ch];
			end
		end
	end

endmodule

// File: function_generator.sv
`timescale 1ns/1ns

`include "fg_settings.svh"

module function_generator (
	input logic clock,
	input logic reset,
	// host pattern writes
	input logic write_strobe,
	input fg_pkg::write_req_t write_request,
	// host loop bound updates
	input logic bounds_strobe,
	input fg_pkg::chan_t bounds_channel,
	input fg_pkg::loop_bounds_t bounds_in,
	// per channel output enable levels
	input logic [`FG_CHANNELS-1:0] output_enable,
	// playback words, one per channel
	output fg_pkg::word_vec_t data_out
);

	import fg_pkg::*;

	// shared write path from the host port
	logic [`FG_CHANNELS-1:0] ram_write;
	addr_t ram_address;
	word_t ram_data;

	// bounds per channel, host port to sequencers
	loop_bounds_t bounds [`FG_CHANNELS];

	// sequencer to ram
	addr_t read_address [`FG_CHANNELS];

	// ram to output stage
	word_vec_t read_data;

	// input side
	// registers host writes and keeps the loop bounds
	fg_host_port host_port (
		.clock(clock),
		.reset(reset),
		.write_strobe(write_strobe),
		.write_request(write_request),
		.bounds_strobe(bounds_strobe),
		.bounds_channel(bounds_channel),
		.bounds_in(bounds_in),
		.ram_write(ram_write),
		.ram_address(ram_address),
		.ram_data(ram_data),
		.bounds(bounds)
	);

	// one sequencer and one ram per channel
	for (genvar ch = 0; ch < `FG_CHANNELS; ch++) begin : channel
		// read address counter, wraps between this channel's bounds
		loop_sequencer sequencer (
			.clock(clock),
			.reset(reset),
			.bounds(bounds[ch]),
			.read_address(read_address[ch])
		);

		// pattern storage for this channel
		// written from the host, read by the sequencer
		pattern_ram #(
			.depth_bits(`FG_ADDR_WIDTH)
		) ram (
			.clock(clock),
			.write_enable(ram_write[ch]),
			.write_address(ram_address),
			.write_data(ram_data),
			.read_address(read_address[ch]),
			.read_data(read_data[ch])
		);
	end

	// output side
	// aligns and masks all channel words
	fg_output_stage output_stage (
		.clock(clock),
		.reset(reset),
		.output_enable(output_enable),
		.read_data(read_data),
		.data_out(data_out)
	);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	// 4 ns period with the first rising edge at 2 ns
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// reset held for 5 rising edges and released just after the fifth
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

// File: function_generator_tb.sv
`timescale 1ns/1ns

`include "fg_settings.svh"

module function_generator_tb;

	import fg_pkg::*;

	// four ram loads plus two full-range wraps for each of six tests plus margin
	localparam int watchdog_cycles = (`FG_CHANNELS + 12) * (1 << `FG_ADDR_WIDTH) + 27232;
	// longest wait for a new loop to start is two full-range passes
	localparam int lock_limit = 2 * (1 << `FG_ADDR_WIDTH);

	logic clock;
	logic reset;
	logic write_strobe;
	write_req_t write_request;
	logic bounds_strobe;
	chan_t bounds_channel;
	loop_bounds_t bounds_in;
	logic [`FG_CHANNELS-1:0] output_enable;
	word_vec_t data_out;

	// loop bounds last given to each channel
	int loop_start [`FG_CHANNELS];
	int loop_end [`FG_CHANNELS];
	// previous sample of the outputs
	word_vec_t last_out;

	tb_clock_gen clock_gen (.clock(clock), .reset(reset));

	function_generator uut (
		.clock(clock),
		.reset(reset),
		.write_strobe(write_strobe),
		.write_request(write_request),
		.bounds_strobe(bounds_strobe),
		.bounds_channel(bounds_channel),
		.bounds_in(bounds_in),
		.output_enable(output_enable),
		.data_out(data_out)
	);

	// drive and sample 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic stop_with_error(input string text);
		$display("%s", text);
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			stop_with_error($sformatf("mismatch in %s: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	task automatic check_vec(input string name, input word_vec_t expected,
			input word_vec_t actual);
		if (actual !== expected) begin
			stop_with_error($sformatf("mismatch in %s: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	// low 6 address bits with the channel tag on top
	function automatic word_t pattern_word(input int ch, input int address);
		return word_t'((address % 64) + ch * 64);
	endfunction

	// word that must follow prev
	// start after end minus one and the next address otherwise
	function automatic word_t next_word(input int ch, input word_t prev);
		int low;
		int last_low;
		low = int'(prev[5:0]);
		last_low = (loop_end[ch] - 1) & 63;
		if (low == last_low) begin
			return pattern_word(ch, loop_start[ch]);
		end
		return pattern_word(ch, low + 1);
	endfunction

	task automatic load_channel(input int ch);
		for (int address = 0; address < (1 << `FG_ADDR_WIDTH); address++) begin
			write_strobe = 1'b1;
			write_request.channel = chan_t'(ch);
			write_request.address = addr_t'(address);
			write_request.data = pattern_word(ch, address);
			next_cycle();
		end
		write_strobe = 1'b0;
		// last word lands 2 cycles after its strobe
		repeat (2) next_cycle();
	endtask

	task automatic set_bounds(input int ch, input int start, input int stop);
		bounds_strobe = 1'b1;
		bounds_channel = chan_t'(ch);
		bounds_in.start_address = addr_t'(start);
		bounds_in.end_address = addr_t'(stop);
		loop_start[ch] = start;
		loop_end[ch] = stop;
		next_cycle();
		bounds_strobe = 1'b0;
	endtask

	// start word right after a break in the sequence
	task automatic wait_loop_start(input int ch);
		word_t prev;
		word_t start_word;
		word_t before_start;
		int waited;
		start_word = pattern_word(ch, loop_start[ch]);
		before_start = pattern_word(ch, loop_start[ch] + 63);
		waited = 0;
		prev = data_out[ch];
		next_cycle();
		while (!(data_out[ch] == start_word && prev != before_start)) begin
			if (waited == lock_limit) begin
				stop_with_error($sformatf("channel %0d never jumped to loop start %0d",
					ch, loop_start[ch]));
			end
			prev = data_out[ch];
			next_cycle();
			waited++;
		end
	endtask

	// enabled channels follow the sequencer rule and disabled ones stay zero
	task automatic check_playback(input string name, input int cycles);
		word_vec_t expected;
		last_out = data_out;
		for (int i = 0; i < cycles; i++) begin
			next_cycle();
			for (int ch = 0; ch < `FG_CHANNELS; ch++) begin
				expected[ch] = output_enable[ch] ? next_word(ch, last_out[ch]) : '0;
			end
			check_vec(name, expected, data_out);
			last_out = data_out;
		end
	endtask

	task automatic reset_values();
		for (int i = 0; i < 8; i++) begin
			check_vec("reset", '0, data_out);
			next_cycle();
		end
	endtask

	task automatic full_range_playback();
		output_enable[0] = 1'b1;
		load_channel(0);
		repeat (3) next_cycle();
		// 3000 samples pass the 2047 to 0 wrap
		check_playback("full range", 3000);
	endtask

	task automatic loop_bounds();
		set_bounds(0, 100, 110);
		wait_loop_start(0);
		// five passes over 100 to 109
		check_playback("loop bounds", 50);
	endtask

	task automatic independent_channels();
		int start;
		int length;
		output_enable = '1;
		for (int ch = 1; ch < `FG_CHANNELS; ch++) begin
			load_channel(ch);
		end
		repeat (3) next_cycle();
		// start low bits 1 to 30 so the jump always shows as a break
		for (int ch = 0; ch < `FG_CHANNELS; ch++) begin
			start = 64 * int'($urandom % 31) + 1 + int'($urandom % 30);
			length = 2 + int'($urandom % 24);
			set_bounds(ch, start, start + length);
		end
		for (int ch = 0; ch < `FG_CHANNELS; ch++) begin
			wait_loop_start(ch);
		end
		check_playback("independent channels", 200);
	endtask

	task automatic enable_masking();
		output_enable[2] = 1'b0;
		// mask shows one cycle after the enable drops
		next_cycle();
		check_playback("enable masking", 30);
		output_enable[2] = 1'b1;
		next_cycle();
		check_playback("enable restore", 30);
	endtask

	task automatic live_rewrite();
		word_t new_words [8];
		set_bounds(1, 1072, 1080);
		wait_loop_start(1);
		// output now shows address 1072 and steps once per cycle
		for (int i = 0; i < 8; i++) begin
			new_words[i] = word_t'($urandom);
			write_strobe = 1'b1;
			write_request.channel = chan_t'(1);
			write_request.address = addr_t'(1072 + i);
			write_request.data = new_words[i];
			next_cycle();
		end
		write_strobe = 1'b0;
		// let one full loop pass before reading back from 1072
		repeat (8) next_cycle();
		for (int i = 0; i < 8; i++) begin
			check_word("live rewrite", new_words[i], data_out[1]);
			next_cycle();
		end
	endtask

	initial begin
		write_strobe = 1'b0;
		write_request = '0;
		bounds_strobe = 1'b0;
		bounds_channel = '0;
		bounds_in = '0;
		output_enable = '0;
		for (int ch = 0; ch < `FG_CHANNELS; ch++) begin
			loop_start[ch] = 0;
			loop_end[ch] = 0;
		end
		void'($urandom(51));
		next_cycle();
		while (reset) begin
			next_cycle();
		end
		reset_values();
		full_range_playback();
		loop_bounds();
		independent_channels();
		enable_masking();
		live_rewrite();
		$display("Testbench passed");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("Testbench failed");
		$fatal(1, "watchdog expired before the tests finished");
	end

endmodule

// File: project.f
+incdir+.
fg_pkg.sv
fg_host_port.sv
pattern_ram.sv
loop_sequencer.sv
fg_output_stage.sv
function_generator.sv
tb_clock_gen.sv
function_generator_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the function generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f project.f \
	--top-module function_generator_tb -o function_generator_sim
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

./obj_dir/function_generator_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi

exit 0
